//--- calc.f
verilog/calc_pkg.sv
verilog/calc_bypass.sv
verilog/calc_pipe_int.sv
verilog/calc_pipe_mul.sv
verilog/calc_completion.sv
verilog/calc_top.sv
tb/calc_tb.sv

//--- tb/calc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module calc_tb;

  localparam int reset_cycles_lp = 16;
  localparam int test_cycles_lp  = 600;
  localparam int timeout_lp      = reset_cycles_lp + test_cycles_lp + 20;
  localparam int dw_lp           = calc_pkg::dword_width_lp;
  localparam int aw_lp           = calc_pkg::reg_addr_width_lp;
  localparam int iw_lp           = calc_pkg::imm_width_lp;

  typedef struct packed
  {
    logic [31:0]           due;
    logic [dw_lp-1:0]      pc;
    calc_pkg::calc_instr_u instr;
  } commit_exp_s;

  typedef struct packed
  {
    logic [31:0]      due;
    logic [aw_lp-1:0] rd;
    logic [dw_lp-1:0] data;
  } wb_exp_s;

  logic                  clk_i;
  logic                  reset_i;
  logic                  dispatch_v_i;
  calc_pkg::calc_instr_u dispatch_instr_i;
  logic [dw_lp-1:0]      dispatch_pc_i;
  logic [dw_lp-1:0]      dispatch_rs1_i;
  logic [dw_lp-1:0]      dispatch_rs2_i;
  logic                  dispatch_poison_i;
  logic                  flush_i;
  logic                  commit_v_o;
  logic [dw_lp-1:0]      commit_pc_o;
  calc_pkg::calc_instr_u commit_instr_o;
  logic                  wb_v_o;
  logic [aw_lp-1:0]      wb_rd_addr_o;
  logic [dw_lp-1:0]      wb_rd_data_o;

  logic [31:0] seed;
  int          cyc;
  int          slot;
  int          error_count;
  int          commit_count;
  int          wb_count;
  logic        run_done;

  // Register file written by the DUT, arch holds the in-order reference state
  logic [dw_lp-1:0] rf [32];
  logic [dw_lp-1:0] arch [32];
  logic             flush_plan [test_cycles_lp+4];
  logic [calc_pkg::opcode_width_lp-1:0] op_table [8];
  logic             prev_mul_v;
  logic [aw_lp-1:0] prev_mul_rd;

  commit_exp_s commit_q [$];
  wb_exp_s     wb_q [$];

  logic                  exp_commit_v;
  logic [dw_lp-1:0]      exp_commit_pc;
  calc_pkg::calc_instr_u exp_commit_instr;
  logic                  exp_wb_v;
  logic [aw_lp-1:0]      exp_wb_rd;
  logic [dw_lp-1:0]      exp_wb_data;

  calc_top calc_top_inst
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.dispatch_instr_i(dispatch_instr_i)
     ,.dispatch_pc_i(dispatch_pc_i)
     ,.dispatch_rs1_i(dispatch_rs1_i)
     ,.dispatch_rs2_i(dispatch_rs2_i)
     ,.dispatch_poison_i(dispatch_poison_i)
     ,.flush_i(flush_i)
     ,.commit_v_o(commit_v_o)
     ,.commit_pc_o(commit_pc_o)
     ,.commit_instr_o(commit_instr_o)
     ,.wb_v_o(wb_v_o)
     ,.wb_rd_addr_o(wb_rd_addr_o)
     ,.wb_rd_data_o(wb_rd_data_o)
     );

  function automatic logic [15:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:15];
  endfunction

  function automatic logic [dw_lp-1:0] rand64();
    logic [dw_lp-1:0] v;
    v = '0;
    for (int k = 0; k < 4; k++)
      v = {v[dw_lp-17:0], lcg_next()};
    return v;
  endfunction

  initial
    begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
    end

  initial
    begin
      seed              = 32'd39778;
      reset_i           = 1'b1;
      dispatch_v_i      = 1'b0;
      dispatch_instr_i  = '0;
      dispatch_pc_i     = '0;
      dispatch_poison_i = 1'b0;
      flush_i           = 1'b0;
      cyc               = 0;
      slot              = 0;
      error_count       = 0;
      commit_count      = 0;
      wb_count          = 0;
      run_done          = 1'b0;
      prev_mul_v        = 1'b0;
      prev_mul_rd       = '0;
      exp_commit_v      = 1'b0;
      exp_wb_v          = 1'b0;
      op_table = '{calc_pkg::op_add_lp, calc_pkg::op_sub_lp, calc_pkg::op_and_lp,
                   calc_pkg::op_or_lp, calc_pkg::op_xor_lp, calc_pkg::op_slt_lp,
                   calc_pkg::op_addi_lp, calc_pkg::op_mul_lp};
      for (int i = 0; i < 32; i++)
        begin
          arch[i] = (i == 0) ? '0 : rand64();
          rf[i]   = arch[i];
        end
      // Roughly one flush every 32 slots, none in the drain
      for (int i = 0; i < test_cycles_lp + 4; i++)
        flush_plan[i] = (i < test_cycles_lp) && (lcg_next() % 32 == 0);
    end

  // Read port with write-through of the writeback in the same cycle
  always_comb
    begin
      dispatch_rs1_i = rf[dispatch_instr_i.rtype.rs1_addr];
      dispatch_rs2_i = rf[dispatch_instr_i.rtype.rs2_addr];
      if (wb_v_o && (wb_rd_addr_o == dispatch_instr_i.rtype.rs1_addr))
        dispatch_rs1_i = wb_rd_data_o;
      if (wb_v_o && (wb_rd_addr_o == dispatch_instr_i.rtype.rs2_addr))
        dispatch_rs2_i = wb_rd_data_o;
    end

  task automatic issue_instruction(input int edge_idx);
    calc_pkg::calc_instr_u instr;
    logic [15:0] r1;
    logic [15:0] r2;
    logic [15:0] r3;
    logic [calc_pkg::opcode_width_lp-1:0] op;
    logic [aw_lp-1:0] rd;
    logic [aw_lp-1:0] rs1;
    logic [aw_lp-1:0] rs2;
    logic [iw_lp-1:0] imm;
    logic [dw_lp-1:0] a;
    logic [dw_lp-1:0] b;
    logic [dw_lp-1:0] res;
    logic [dw_lp-1:0] pc;
    logic v;
    logic poison;
    logic commit_kill;
    logic wb_kill;
    r1     = lcg_next();
    r2     = lcg_next();
    r3     = lcg_next();
    op     = op_table[r1[2:0]];
    rd     = {2'b00, r1[5:3]};
    rs1    = {2'b00, r1[8:6]};
    rs2    = {2'b00, r1[11:9]};
    imm    = {r2[1:0], r3};
    v      = (r1[15:12] != 4'h0);
    poison = (r2[15:12] == 4'h0);
    pc     = 64'h1000 + 64'(slot) * 64'd4;
    // Multiply result is not forwardable in the next slot
    if (prev_mul_v && (prev_mul_rd != '0))
      begin
        if (rs1 == prev_mul_rd)
          rs1 = rs1 + 1'b1;
        if ((op != calc_pkg::op_addi_lp) && (rs2 == prev_mul_rd))
          rs2 = rs2 + 1'b1;
      end
    prev_mul_v  = v && (op == calc_pkg::op_mul_lp);
    prev_mul_rd = rd;
    instr                = '0;
    instr.rtype.opcode   = op;
    instr.rtype.rd_addr  = rd;
    instr.rtype.rs1_addr = rs1;
    if (op == calc_pkg::op_addi_lp)
      instr.itype.imm = imm;
    else
      instr.rtype.rs2_addr = rs2;
    a = arch[rs1];
    b = arch[rs2];
    case (op)
      calc_pkg::op_add_lp  : res = a + b;
      calc_pkg::op_sub_lp  : res = a - b;
      calc_pkg::op_and_lp  : res = a & b;
      calc_pkg::op_or_lp   : res = a | b;
      calc_pkg::op_xor_lp  : res = a ^ b;
      calc_pkg::op_slt_lp  : res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      calc_pkg::op_addi_lp : res = a + {{(dw_lp-iw_lp){imm[iw_lp-1]}}, imm};
      default              : res = a * b;
    endcase
    // Flush reaches back two slots for commit and three for writeback
    commit_kill = poison | flush_plan[slot] | flush_plan[slot+1] | flush_plan[slot+2];
    wb_kill     = commit_kill | flush_plan[slot+3];
    if (v && !commit_kill)
      commit_q.push_back(commit_exp_s'{edge_idx + 3, pc, instr});
    if (v && !wb_kill && (rd != '0))
      begin
        wb_q.push_back(wb_exp_s'{edge_idx + 4, rd, res});
        arch[rd] = res;
      end
    dispatch_v_i      <= v;
    dispatch_instr_i  <= instr;
    dispatch_pc_i     <= pc;
    dispatch_poison_i <= poison;
    flush_i           <= flush_plan[slot];
    slot = slot + 1;
  endtask

  always @(posedge clk_i)
    begin
      cyc <= cyc + 1;
      if (cyc == reset_cycles_lp - 1)
        reset_i <= 1'b0;
      if (wb_v_o)
        rf[wb_rd_addr_o] <= wb_rd_data_o;
      if (!reset_i && commit_v_o)
        commit_count++;
      if (!reset_i && wb_v_o)
        wb_count++;
      // Expected outputs for the cycle that starts at this edge
      exp_commit_v <= 1'b0;
      if ((commit_q.size() != 0) && (commit_q[0].due == cyc))
        begin
          exp_commit_v     <= 1'b1;
          exp_commit_pc    <= commit_q[0].pc;
          exp_commit_instr <= commit_q[0].instr;
          void'(commit_q.pop_front());
        end
      exp_wb_v <= 1'b0;
      if ((wb_q.size() != 0) && (wb_q[0].due == cyc))
        begin
          exp_wb_v    <= 1'b1;
          exp_wb_rd   <= wb_q[0].rd;
          exp_wb_data <= wb_q[0].data;
          void'(wb_q.pop_front());
        end
      if (!reset_i && (slot < test_cycles_lp))
        issue_instruction(cyc);
      else
        begin
          dispatch_v_i      <= 1'b0;
          dispatch_poison_i <= 1'b0;
          flush_i           <= 1'b0;
        end
      run_done <= (slot == test_cycles_lp) && (commit_q.size() == 0) && (wb_q.size() == 0);
    end

  always @(posedge clk_i)
    begin
      if (cyc == timeout_lp)
        begin
          $display("Timeout after %0d cycles, the expected results never drained", cyc);
          $display("Simulation finished: FAIL");
          $finish;
        end
    end

  commit_v_chk : assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o == exp_commit_v)
    else
      begin
        error_count++;
        $display("Error: commit_v_o got %h expected %h", $sampled(commit_v_o),
                 $sampled(exp_commit_v));
      end

  commit_pc_chk : assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o |-> (commit_pc_o == exp_commit_pc))
    else
      begin
        error_count++;
        $display("Error: commit_pc_o got %h expected %h", $sampled(commit_pc_o),
                 $sampled(exp_commit_pc));
      end

  commit_instr_chk : assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o |-> (commit_instr_o == exp_commit_instr))
    else
      begin
        error_count++;
        $display("Error: commit_instr_o got %h expected %h", $sampled(commit_instr_o),
                 $sampled(exp_commit_instr));
      end

  wb_v_chk : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o == exp_wb_v)
    else
      begin
        error_count++;
        $display("Error: wb_v_o got %h expected %h", $sampled(wb_v_o), $sampled(exp_wb_v));
      end

  wb_rd_chk : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> (wb_rd_addr_o == exp_wb_rd))
    else
      begin
        error_count++;
        $display("Error: wb_rd_addr_o got %h expected %h", $sampled(wb_rd_addr_o),
                 $sampled(exp_wb_rd));
      end

  wb_data_chk : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> (wb_rd_data_o == exp_wb_data))
    else
      begin
        error_count++;
        $display("Error: wb_rd_data_o got %h expected %h", $sampled(wb_rd_data_o),
                 $sampled(exp_wb_data));
      end

  initial
    begin
      wait (run_done);
      repeat (3) @(posedge clk_i);
      $display("Commits %0d, writebacks %0d, errors %0d", commit_count, wb_count, error_count);
      if (error_count == 0)
        $display("Simulation finished: PASS");
      else
        $display("Simulation finished: FAIL");
      $finish;
    end

endmodule

`default_nettype wire

//--- verilog/calc_top.sv
`timescale 1ns/100ps
`default_nettype none

module calc_top
 (input  logic                                  clk_i
  , input  logic                                reset_i

  , input  logic                                dispatch_v_i
  , input  calc_pkg::calc_instr_u               dispatch_instr_i
  , input  logic [calc_pkg::dword_width_lp-1:0] dispatch_pc_i
  , input  logic [calc_pkg::dword_width_lp-1:0] dispatch_rs1_i
  , input  logic [calc_pkg::dword_width_lp-1:0] dispatch_rs2_i
  , input  logic                                dispatch_poison_i
  , input  logic                                flush_i

  , output logic                                   commit_v_o
  , output logic [calc_pkg::dword_width_lp-1:0]    commit_pc_o
  , output calc_pkg::calc_instr_u                  commit_instr_o

  , output logic                                   wb_v_o
  , output logic [calc_pkg::reg_addr_width_lp-1:0] wb_rd_addr_o
  , output logic [calc_pkg::dword_width_lp-1:0]    wb_rd_data_o
  );

  logic [calc_pkg::wb_point_lp:1]                                   fwd_rd_v;
  logic [calc_pkg::wb_point_lp:1][calc_pkg::reg_addr_width_lp-1:0]  fwd_rd_addr;
  logic [calc_pkg::wb_point_lp:1][calc_pkg::dword_width_lp-1:0]     fwd_rd;

  logic [calc_pkg::dword_width_lp-1:0] bypass_rs1;
  logic [calc_pkg::dword_width_lp-1:0] bypass_rs2;

  logic                                 res_v_r;
  calc_pkg::calc_instr_u                res_instr_r;
  logic [calc_pkg::dword_width_lp-1:0]  res_rs1_r;
  logic [calc_pkg::dword_width_lp-1:0]  res_rs2_r;
  logic [calc_pkg::opcode_width_lp-1:0] res_opcode;

  logic [calc_pkg::dword_width_lp-1:0] pipe_int_data_lo;
  logic [calc_pkg::dword_width_lp-1:0] pipe_mul_data_lo;

  // Register file operands may be stale, patch them from in-flight results
  calc_bypass
   #(.fwd_els_p(calc_pkg::wb_point_lp))
   int_bypass
    (.rs1_addr_i(dispatch_instr_i.rtype.rs1_addr)
     ,.rs2_addr_i(dispatch_instr_i.rtype.rs2_addr)
     ,.rs1_i(dispatch_rs1_i)
     ,.rs2_i(dispatch_rs2_i)
     ,.fwd_rd_v_i(fwd_rd_v)
     ,.fwd_rd_addr_i(fwd_rd_addr)
     ,.fwd_rd_i(fwd_rd)
     ,.bypass_rs1_o(bypass_rs1)
     ,.bypass_rs2_o(bypass_rs2)
     );

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        res_v_r <= 1'b0;
      else
        res_v_r <= dispatch_v_i;
    end

  // Reservation payload
  always_ff @(posedge clk_i)
    begin
      res_instr_r <= dispatch_instr_i;
      res_rs1_r   <= bypass_rs1;
      res_rs2_r   <= bypass_rs2;
    end

  // Idle slots run through the ALU as add
  assign res_opcode = res_v_r ? res_instr_r.rtype.opcode : calc_pkg::op_add_lp;

  calc_pipe_int
   pipe_int
    (.opcode_i(res_opcode)
     ,.instr_i(res_instr_r)
     ,.rs1_i(res_rs1_r)
     ,.rs2_i(res_rs2_r)
     ,.data_o(pipe_int_data_lo)
     );

  calc_pipe_mul
   pipe_mul
    (.clk_i(clk_i)
     ,.rs1_i(res_rs1_r)
     ,.rs2_i(res_rs2_r)
     ,.data_o(pipe_mul_data_lo)
     );

  calc_completion
   completion
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.isd_v_i(dispatch_v_i)
     ,.isd_poison_i(dispatch_poison_i)
     ,.flush_i(flush_i)
     ,.isd_pc_i(dispatch_pc_i)
     ,.isd_instr_i(dispatch_instr_i)
     ,.int_data_i(pipe_int_data_lo)
     ,.mul_data_i(pipe_mul_data_lo)
     ,.fwd_rd_v_o(fwd_rd_v)
     ,.fwd_rd_addr_o(fwd_rd_addr)
     ,.fwd_rd_o(fwd_rd)
     ,.commit_v_o(commit_v_o)
     ,.commit_pc_o(commit_pc_o)
     ,.commit_instr_o(commit_instr_o)
     ,.wb_v_o(wb_v_o)
     ,.wb_rd_addr_o(wb_rd_addr_o)
     ,.wb_rd_data_o(wb_rd_data_o)
     );

endmodule

`default_nettype wire

//--- verilog/calc_completion.sv
`timescale 1ns/100ps
`default_nettype none

module calc_completion
 (input  logic                                  clk_i
  , input  logic                                reset_i

  , input  logic                                isd_v_i
  , input  logic                                isd_poison_i
  , input  logic                                flush_i
  , input  logic [calc_pkg::dword_width_lp-1:0] isd_pc_i
  , input  calc_pkg::calc_instr_u               isd_instr_i

  , input  logic [calc_pkg::dword_width_lp-1:0] int_data_i
  , input  logic [calc_pkg::dword_width_lp-1:0] mul_data_i

  , output logic [calc_pkg::wb_point_lp:1]      fwd_rd_v_o
  , output logic [calc_pkg::wb_point_lp:1][calc_pkg::reg_addr_width_lp-1:0] fwd_rd_addr_o
  , output logic [calc_pkg::wb_point_lp:1][calc_pkg::dword_width_lp-1:0]    fwd_rd_o

  , output logic                                 commit_v_o
  , output logic [calc_pkg::dword_width_lp-1:0]  commit_pc_o
  , output calc_pkg::calc_instr_u                commit_instr_o

  , output logic                                 wb_v_o
  , output logic [calc_pkg::reg_addr_width_lp-1:0] wb_rd_addr_o
  , output logic [calc_pkg::dword_width_lp-1:0]  wb_rd_data_o
  );

  localparam int els_lp = calc_pkg::pipe_stage_els_lp;

  logic [els_lp-1:0]                                stage_v_r;
  logic [els_lp-1:0][calc_pkg::dword_width_lp-1:0]  stage_pc_r;
  calc_pkg::calc_instr_u [els_lp-1:0]               stage_instr_r;
  logic [els_lp-1:0]                                stage_mul_r;
  logic [els_lp-1:0]                                stage_w_r;
  logic [els_lp-1:0]                                poison_r;
  logic [els_lp-1:0]                                poison_n;
  logic [els_lp-1:0][calc_pkg::dword_width_lp-1:0]  result_r;
  logic [els_lp-1:0][calc_pkg::dword_width_lp-1:0]  result_n;

  logic isd_mul;
  logic isd_w;
  logic int_sel;
  logic mul_sel;

  // Decode at issue, rd of zero never writes
  assign isd_mul = (isd_instr_i.rtype.opcode == calc_pkg::op_mul_lp);
  assign isd_w   = calc_pkg::op_defined(isd_instr_i.rtype.opcode)
                   & (isd_instr_i.rtype.rd_addr != '0);

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          stage_v_r <= '0;
          poison_r  <= '0;
        end
      else
        begin
          stage_v_r <= {stage_v_r[els_lp-2:0], isd_v_i};
          poison_r  <= poison_n;
        end
    end

  always_ff @(posedge clk_i)
    begin
      stage_pc_r    <= {stage_pc_r[els_lp-2:0], isd_pc_i};
      stage_instr_r <= {stage_instr_r[els_lp-2:0], isd_instr_i};
      stage_mul_r   <= {stage_mul_r[els_lp-2:0], isd_mul};
      stage_w_r     <= {stage_w_r[els_lp-2:0], isd_w};
      result_r      <= result_n;
    end

  // Flush reaches the issuing slot and stages 0 to 2, stage 3 drains untouched
  always_comb
    begin
      poison_n[0] = isd_poison_i | flush_i;
      for (int i = 1; i < els_lp; i++)
        begin
          poison_n[i] = poison_r[i-1] | (flush_i & (i <= calc_pkg::wb_point_lp));
        end
    end

  // Static latencies, each pipe lands its result in its own stage
  assign int_sel = stage_v_r[calc_pkg::int_comp_idx_lp] & ~stage_mul_r[calc_pkg::int_comp_idx_lp];
  assign mul_sel = stage_v_r[calc_pkg::mul_comp_idx_lp] & stage_mul_r[calc_pkg::mul_comp_idx_lp];

  always_comb
    begin
      result_n[0] = '0;
      for (int i = 1; i < els_lp; i++)
        begin
          result_n[i] = result_r[i-1];
        end
      if (int_sel)
        result_n[calc_pkg::int_comp_idx_lp+1] = int_data_i;
      if (mul_sel)
        result_n[calc_pkg::mul_comp_idx_lp+1] = mul_data_i;
    end

  // Forward slices look at what each stage is about to hold
  always_comb
    begin
      for (int i = 1; i <= calc_pkg::wb_point_lp; i++)
        begin
          fwd_rd_v_o[i]    = stage_v_r[i-1] & stage_w_r[i-1] & ~poison_r[i-1];
          fwd_rd_addr_o[i] = stage_instr_r[i-1].rtype.rd_addr;
          fwd_rd_o[i]      = result_n[i];
        end
    end

  assign commit_v_o     = stage_v_r[calc_pkg::commit_point_lp]
                          & ~poison_r[calc_pkg::commit_point_lp];
  assign commit_pc_o    = stage_pc_r[calc_pkg::commit_point_lp];
  assign commit_instr_o = stage_instr_r[calc_pkg::commit_point_lp];

  assign wb_v_o       = stage_v_r[calc_pkg::wb_point_lp] & stage_w_r[calc_pkg::wb_point_lp]
                        & ~poison_r[calc_pkg::wb_point_lp];
  assign wb_rd_addr_o = stage_instr_r[calc_pkg::wb_point_lp].rtype.rd_addr;
  assign wb_rd_data_o = result_r[calc_pkg::wb_point_lp];

  // Integer data only enters for an instruction word that is not a multiply
  mul_not_int_a : assert property (@(posedge clk_i) disable iff (reset_i)
    int_sel
    |-> (stage_instr_r[calc_pkg::int_comp_idx_lp].rtype.opcode != calc_pkg::op_mul_lp))
    else $error("calc_completion: multiply selected as integer result");

  wb_no_x0_a : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> (wb_rd_addr_o != '0))
    else $error("calc_completion: writeback to register 0");

endmodule

`default_nettype wire

//--- verilog/calc_pipe_mul.sv
`timescale 1ns/100ps
`default_nettype none

module calc_pipe_mul
 (input  logic                                 clk_i
  , input  logic [calc_pkg::dword_width_lp-1:0] rs1_i
  , input  logic [calc_pkg::dword_width_lp-1:0] rs2_i

  , output logic [calc_pkg::dword_width_lp-1:0] data_o
  );

  logic [calc_pkg::dword_width_lp-1:0]   rs1_r;
  logic [calc_pkg::dword_width_lp-1:0]   rs2_r;
  logic [2*calc_pkg::dword_width_lp-1:0] product;

  // Operand stage, loaded every cycle
  always_ff @(posedge clk_i)
    begin
      rs1_r <= rs1_i;
      rs2_r <= rs2_i;
    end

  assign product = rs1_r * rs2_r;

  // Low half only
  assign data_o = product[calc_pkg::dword_width_lp-1:0];

endmodule

`default_nettype wire

//--- verilog/calc_pipe_int.sv
`timescale 1ns/100ps
`default_nettype none

module calc_pipe_int
 (input  logic [calc_pkg::opcode_width_lp-1:0] opcode_i
  , input  calc_pkg::calc_instr_u              instr_i
  , input  logic [calc_pkg::dword_width_lp-1:0] rs1_i
  , input  logic [calc_pkg::dword_width_lp-1:0] rs2_i

  , output logic [calc_pkg::dword_width_lp-1:0] data_o
  );

  localparam int ext_width_lp = calc_pkg::dword_width_lp - calc_pkg::imm_width_lp;

  logic [calc_pkg::dword_width_lp-1:0] imm_ext;
  logic                                 slt_bit;

  // Same bits as rs2_addr and pad in the rtype view
  assign imm_ext = {{ext_width_lp{instr_i.itype.imm[calc_pkg::imm_width_lp-1]}},
                    instr_i.itype.imm};

  assign slt_bit = ($signed(rs1_i) < $signed(rs2_i));

  always_comb
    begin
      case (opcode_i)
        calc_pkg::op_add_lp  : data_o = rs1_i + rs2_i;
        calc_pkg::op_sub_lp  : data_o = rs1_i - rs2_i;
        calc_pkg::op_and_lp  : data_o = rs1_i & rs2_i;
        calc_pkg::op_or_lp   : data_o = rs1_i | rs2_i;
        calc_pkg::op_xor_lp  : data_o = rs1_i ^ rs2_i;
        calc_pkg::op_slt_lp  : data_o = {{(calc_pkg::dword_width_lp-1){1'b0}}, slt_bit};
        calc_pkg::op_addi_lp : data_o = rs1_i + imm_ext;
        // Multiply results come from the mul pipe
        default              : data_o = '0;
      endcase
    end

  // Opcode is unknown only before the first reset edge
  always_comb
    begin
      opcode_known_a : assert final ($isunknown(opcode_i) || calc_pkg::op_defined(opcode_i))
        else $error("calc_pipe_int: undefined opcode %h", opcode_i);
    end

endmodule

`default_nettype wire

//--- verilog/calc_bypass.sv
`timescale 1ns/100ps
`default_nettype none

module calc_bypass
 #(parameter int fwd_els_p = 3)
 (input  logic [calc_pkg::reg_addr_width_lp-1:0]                rs1_addr_i
  , input  logic [calc_pkg::reg_addr_width_lp-1:0]              rs2_addr_i
  , input  logic [calc_pkg::dword_width_lp-1:0]                 rs1_i
  , input  logic [calc_pkg::dword_width_lp-1:0]                 rs2_i

  , input  logic [fwd_els_p:1]                                  fwd_rd_v_i
  , input  logic [fwd_els_p:1][calc_pkg::reg_addr_width_lp-1:0] fwd_rd_addr_i
  , input  logic [fwd_els_p:1][calc_pkg::dword_width_lp-1:0]    fwd_rd_i

  , output logic [calc_pkg::dword_width_lp-1:0]                 bypass_rs1_o
  , output logic [calc_pkg::dword_width_lp-1:0]                 bypass_rs2_o
  );

  // Walk from oldest to youngest so the youngest match is the last to win
  function automatic logic [calc_pkg::dword_width_lp-1:0] pick_operand
    (input logic [calc_pkg::reg_addr_width_lp-1:0] addr
     , input logic [calc_pkg::dword_width_lp-1:0]  rf_data
     );
    logic [calc_pkg::dword_width_lp-1:0] data;
    data = rf_data;
    for (int i = fwd_els_p; i >= 1; i--)
      begin
        if (fwd_rd_v_i[i] && (fwd_rd_addr_i[i] == addr) && (addr != '0))
          begin
            data = fwd_rd_i[i];
          end
      end
    return data;
  endfunction

  always_comb
    begin
      bypass_rs1_o = pick_operand(rs1_addr_i, rs1_i);
      bypass_rs2_o = pick_operand(rs2_addr_i, rs2_i);
    end

endmodule

`default_nettype wire

//--- verilog/calc_pkg.sv
`default_nettype none

package calc_pkg;

  // Datapath and register file geometry
  localparam int dword_width_lp    = 64;
  localparam int reg_addr_width_lp = 5;
  localparam int instr_width_lp    = 32;
  localparam int opcode_width_lp   = 4;

  // Field widths left over once opcode and register indices are placed
  localparam int imm_width_lp       = instr_width_lp - opcode_width_lp - 2*reg_addr_width_lp;
  localparam int rtype_pad_width_lp = imm_width_lp - reg_addr_width_lp;

  // Completion pipe layout
  localparam int pipe_stage_els_lp = 5;
  localparam int int_comp_idx_lp   = 0;
  localparam int mul_comp_idx_lp   = 1;
  localparam int commit_point_lp   = 2;
  localparam int wb_point_lp       = 3;

  // Opcode encodings
  localparam logic [opcode_width_lp-1:0] op_add_lp  = 4'h0;
  localparam logic [opcode_width_lp-1:0] op_sub_lp  = 4'h1;
  localparam logic [opcode_width_lp-1:0] op_and_lp  = 4'h2;
  localparam logic [opcode_width_lp-1:0] op_or_lp   = 4'h3;
  localparam logic [opcode_width_lp-1:0] op_xor_lp  = 4'h4;
  localparam logic [opcode_width_lp-1:0] op_slt_lp  = 4'h5;
  localparam logic [opcode_width_lp-1:0] op_addi_lp = 4'h6;
  localparam logic [opcode_width_lp-1:0] op_mul_lp  = 4'h7;

  // Register-register format
  typedef struct packed
  {
    logic [opcode_width_lp-1:0]    opcode;
    logic [reg_addr_width_lp-1:0]  rd_addr;
    logic [reg_addr_width_lp-1:0]  rs1_addr;
    logic [reg_addr_width_lp-1:0]  rs2_addr;
    logic [rtype_pad_width_lp-1:0] pad;
  } calc_rtype_s;

  // Register-immediate format, imm is sign extended by the ALU
  typedef struct packed
  {
    logic [opcode_width_lp-1:0]   opcode;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic [reg_addr_width_lp-1:0] rs1_addr;
    logic [imm_width_lp-1:0]      imm;
  } calc_itype_s;

  typedef union packed
  {
    calc_rtype_s rtype;
    calc_itype_s itype;
  } calc_instr_u;

  // Every defined opcode writes rd
  function automatic logic op_defined(input logic [opcode_width_lp-1:0] op);
    return op inside {op_add_lp, op_sub_lp, op_and_lp, op_or_lp,
                      op_xor_lp, op_slt_lp, op_addi_lp, op_mul_lp};
  endfunction

endpackage

`default_nettype wire
